// ==== cache_pkg.sv ====
package cache_pkg;

    // cache geometry
    localparam int num_ways       = 2;
    localparam int num_sets       = 256;
    localparam int words_per_line = 4;

    typedef logic [7:0]  index_t;
    typedef logic [19:0] tag_t;
    typedef logic [3:0]  offset_t;  // byte offset in line, [3:2] picks the word

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_e;

    typedef struct packed {
        op_e         op;
        index_t      index;
        tag_t        tag;
        offset_t     offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    // one-hot main FSM
    typedef enum logic [4:0] {
        st_idle    = 5'b00001,
        st_lookup  = 5'b00010,
        st_miss    = 5'b00100,
        st_replace = 5'b01000,
        st_refill  = 5'b10000
    } main_state_e;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    typedef struct packed {
        logic [num_ways-1:0] way_hit;
        logic                hit;
        logic                hit_way;
        logic                victim_valid;
        logic                victim_dirty;
        tag_t                victim_tag;
    } lookup_res_t;

endpackage

// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

    // word 0 sits in bits [31:0]
    typedef logic [3:0][31:0] line_t;

    // memory side only ever sees line aligned addresses
    typedef struct packed {
        cache_pkg::tag_t   tag;
        cache_pkg::index_t index;
        logic [3:0]        pad;    // always zero
    } line_addr_t;

    typedef logic [1:0] beat_t;    // refill beat number

endpackage

// ==== cache_arrays.sv ====
module cache_arrays (
    input  logic                                         clk,
    input  logic                                         resetn,
    input  cache_pkg::main_state_e                       state,
    input  cache_pkg::index_t                            rd_index,
    input  logic                                         sb_wen,
    input  logic                                         sb_way,
    input  cache_pkg::index_t                            sb_index,
    input  logic [1:0]                                   sb_bank,
    input  logic [3:0]                                   sb_wstrb,
    input  logic [31:0]                                  sb_wdata,
    input  logic                                         victim_way,
    input  cache_pkg::index_t                            refill_index,
    input  logic [cache_pkg::words_per_line-1:0]         refill_wen,
    input  logic [31:0]                                  refill_wdata,
    input  logic                                         tag_wen,
    input  cache_pkg::tag_t                              refill_tag,
    output cache_pkg::tagv_t [cache_pkg::num_ways-1:0]   tagv_rd,
    output logic [cache_pkg::num_ways-1:0]               dirty_rd,
    output mem_bus_pkg::line_t [cache_pkg::num_ways-1:0] bank_rd
);

    logic [cache_pkg::num_ways-1:0][cache_pkg::num_sets-1:0] valid_q;
    logic [cache_pkg::num_ways-1:0][cache_pkg::num_sets-1:0] dirty_q;
    cache_pkg::tag_t tag_mem [cache_pkg::num_ways][cache_pkg::num_sets];
    cache_pkg::tag_t [cache_pkg::num_ways-1:0]               tag_rd;
    logic [cache_pkg::num_ways-1:0]                          valid_rd;
    cache_pkg::index_t                                       tag_addr;
    cache_pkg::index_t                                       bank_addr [cache_pkg::words_per_line];

    // lookup reads the incoming index, miss handling the buffered one
    assign tag_addr = (state == cache_pkg::st_idle || state == cache_pkg::st_lookup) ?
                      rd_index : refill_index;

    always_comb begin
        for (int b = 0; b < cache_pkg::words_per_line; b++) begin
            bank_addr[b] = (sb_wen && sb_bank == b) ? sb_index : tag_addr;  // store owns its bank
        end
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            tagv_rd[w].tag   = tag_rd[w];
            tagv_rd[w].valid = valid_rd[w];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            valid_rd <= '0;
            dirty_rd <= '0;
        end else begin
            if (tag_wen) begin
                valid_q[victim_way][refill_index] <= 1'b1;
                dirty_q[victim_way][refill_index] <= 1'b0;
            end
            if (sb_wen) begin
                dirty_q[sb_way][sb_index] <= 1'b1;
            end
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                valid_rd[w] <= valid_q[w][tag_addr];
                dirty_rd[w] <= dirty_q[w][tag_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_wen) begin
            tag_mem[victim_way][refill_index] <= refill_tag;
        end
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            tag_rd[w] <= tag_mem[w][tag_addr];
        end
    end

    for (genvar w = 0; w < cache_pkg::num_ways; w++) begin : g_way
        for (genvar b = 0; b < cache_pkg::words_per_line; b++) begin : g_bank
            logic [3:0][7:0] mem [cache_pkg::num_sets];
            logic [31:0]     rd_q;
            logic            sb_sel;
            logic [3:0]      wen;
            logic [31:0]     wdata;

            assign sb_sel = sb_wen && sb_way == w && sb_bank == b;
            assign wen    = sb_sel ? sb_wstrb : {4{refill_wen[b] && victim_way == w}};
            assign wdata  = sb_sel ? sb_wdata : refill_wdata;

            always_ff @(posedge clk) begin
                for (int i = 0; i < 4; i++) begin
                    if (wen[i]) begin
                        mem[bank_addr[b]][i] <= wdata[8*i +: 8];
                    end
                end
                rd_q <= mem[bank_addr[b]];  // read before write
            end

            assign bank_rd[w][b] = rd_q;
        end
    end

endmodule

// ==== hit_lookup.sv ====
module hit_lookup (
    input  logic                                         clk,
    input  logic                                         resetn,
    input  logic                                         valid,
    input  cache_pkg::cpu_req_t                          req,
    input  cache_pkg::main_state_e                       state,
    input  logic                                         victim_way,
    input  cache_pkg::tagv_t [cache_pkg::num_ways-1:0]   tagv_rd,
    input  logic [cache_pkg::num_ways-1:0]               dirty_rd,
    input  mem_bus_pkg::line_t [cache_pkg::num_ways-1:0] bank_rd,
    output logic                                         addr_ok,
    output cache_pkg::cpu_req_t                          buf_req,
    output cache_pkg::lookup_res_t                       lres,
    output logic [31:0]                                  hit_rdata,
    output logic                                         sb_wen,
    output logic                                         sb_way,
    output cache_pkg::index_t                            sb_index,
    output logic [1:0]                                   sb_bank,
    output logic [3:0]                                   sb_wstrb,
    output logic [31:0]                                  sb_wdata
);

    logic store_hit;
    logic fill_store;
    logic was_refill;
    logic fill_way;
    logic rd_conflict;

    always_comb begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            lres.way_hit[w] = tagv_rd[w].valid && tagv_rd[w].tag == buf_req.tag;
        end
        lres.hit          = |lres.way_hit;
        lres.hit_way      = lres.way_hit[1];
        lres.victim_valid = tagv_rd[victim_way].valid;
        lres.victim_dirty = dirty_rd[victim_way];
        lres.victim_tag   = tagv_rd[victim_way].tag;
    end

    assign hit_rdata = bank_rd[lres.hit_way][buf_req.offset[3:2]];

    assign store_hit  = state == cache_pkg::st_lookup && buf_req.op == cache_pkg::op_write
                        && lres.hit;
    // store replayed once the write miss refill is over so the new line turns dirty
    assign fill_store = was_refill && state == cache_pkg::st_idle
                        && buf_req.op == cache_pkg::op_write;

    // read vs store in lookup to the same word, or vs the bank being written
    assign rd_conflict = req.op == cache_pkg::op_read
                         && ((state == cache_pkg::st_lookup && buf_req.op == cache_pkg::op_write
                              && {req.tag, req.index, req.offset[3:2]}
                                 == {buf_req.tag, buf_req.index, buf_req.offset[3:2]})
                             || (sb_wen && req.offset[3:2] == sb_bank));

    assign addr_ok = (state == cache_pkg::st_idle || (state == cache_pkg::st_lookup && lres.hit))
                     && !rd_conflict;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_req    <= '0;
            sb_wen     <= 1'b0;
            was_refill <= 1'b0;
        end else begin
            if (valid && addr_ok) begin
                buf_req <= req;
            end
            sb_wen     <= store_hit || fill_store;
            was_refill <= state == cache_pkg::st_refill;
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::st_refill) begin
            fill_way <= victim_way;  // lfsr moves on the last beat
        end
        if (store_hit || fill_store) begin
            sb_way   <= store_hit ? lres.hit_way : fill_way;
            sb_index <= buf_req.index;
            sb_bank  <= buf_req.offset[3:2];
            sb_wstrb <= buf_req.wstrb;
            sb_wdata <= buf_req.wdata;
        end
    end

endmodule

// ==== miss_ctrl.sv ====
module miss_ctrl #(
    parameter logic [7:0] lfsr_seed = 8'h01
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 valid,
    input  logic                                 addr_ok,
    input  cache_pkg::cpu_req_t                  buf_req,
    input  cache_pkg::lookup_res_t               lres,
    input  logic [31:0]                          hit_rdata,
    input  logic                                 rd_rdy,
    input  logic                                 ret_valid,
    input  logic                                 ret_last,
    input  logic [31:0]                          ret_data,
    input  logic                                 wr_rdy,
    input  mem_bus_pkg::line_t                   victim_line,
    output cache_pkg::main_state_e               state,
    output logic                                 victim_way,
    output logic [cache_pkg::words_per_line-1:0] refill_wen,
    output logic [31:0]                          refill_wdata,
    output logic                                 tag_wen,
    output logic                                 data_ok,
    output logic [31:0]                          rdata,
    output logic                                 rd_req,
    output mem_bus_pkg::line_addr_t              rd_addr,
    output logic                                 wr_req,
    output mem_bus_pkg::line_addr_t              wr_addr,
    output mem_bus_pkg::line_t                   wr_data
);

    cache_pkg::main_state_e next_state;
    logic [7:0]             lfsr;
    mem_bus_pkg::beat_t     beat;
    logic                   first_replace;
    logic                   beat_in;
    logic                   last_beat;
    logic                   crit_beat;
    logic                   is_store;
    logic [31:0]            wmask;

    assign is_store  = buf_req.op == cache_pkg::op_write;
    assign beat_in   = state == cache_pkg::st_refill && ret_valid;
    assign last_beat = beat_in && ret_last;
    assign crit_beat = beat_in && beat == buf_req.offset[3:2];  // the word the cpu asked for

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= cache_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            cache_pkg::st_idle:
                next_state = (valid && addr_ok) ? cache_pkg::st_lookup : cache_pkg::st_idle;
            cache_pkg::st_lookup:
                if (valid && addr_ok) begin
                    next_state = cache_pkg::st_lookup;
                end else if (lres.hit) begin
                    next_state = cache_pkg::st_idle;
                end else begin
                    next_state = cache_pkg::st_miss;
                end
            cache_pkg::st_miss:
                next_state = wr_rdy ? cache_pkg::st_replace : cache_pkg::st_miss;
            cache_pkg::st_replace:
                next_state = rd_rdy ? cache_pkg::st_refill : cache_pkg::st_replace;
            cache_pkg::st_refill:
                next_state = last_beat ? cache_pkg::st_idle : cache_pkg::st_refill;
            default:
                next_state = cache_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr          <= lfsr_seed;
            beat          <= '0;
            first_replace <= 1'b0;
        end else begin
            if (last_beat) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
            if (beat_in) begin
                beat <= ret_last ? '0 : beat + 2'd1;
            end
            first_replace <= state == cache_pkg::st_miss && wr_rdy;
        end
    end

    assign victim_way = lfsr[0];

    // write-back of the victim, only when it holds modified data
    assign wr_req  = first_replace && lres.victim_valid && lres.victim_dirty;
    assign wr_addr = '{tag: lres.victim_tag, index: buf_req.index, pad: 4'h0};
    assign wr_data = victim_line;

    assign rd_req  = state == cache_pkg::st_replace;
    assign rd_addr = '{tag: buf_req.tag, index: buf_req.index, pad: 4'h0};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            wmask[8*i +: 8] = {8{buf_req.wstrb[i]}};
        end
        for (int b = 0; b < cache_pkg::words_per_line; b++) begin
            refill_wen[b] = beat_in && beat == b;
        end
    end

    // store data lands on top of the returned word
    assign refill_wdata = (crit_beat && is_store) ? (buf_req.wdata & wmask) | (ret_data & ~wmask)
                                                  : ret_data;
    assign tag_wen      = last_beat;

    assign data_ok = (state == cache_pkg::st_lookup && (lres.hit || is_store))
                     || (crit_beat && !is_store);
    assign rdata   = (state == cache_pkg::st_lookup) ? hit_rdata : ret_data;

endmodule

// ==== cache_top.sv ====
module cache_top #(
    parameter logic [7:0] lfsr_seed = 8'h01
) (
    input  logic                    clk,
    input  logic                    resetn,
    // cpu side
    input  logic                    valid,
    input  cache_pkg::cpu_req_t     req,
    output logic                    addr_ok,
    output logic                    data_ok,
    output logic [31:0]             rdata,
    // line read
    output logic                    rd_req,
    output mem_bus_pkg::line_addr_t rd_addr,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  logic [31:0]             ret_data,
    // line write-back
    output logic                    wr_req,
    output mem_bus_pkg::line_addr_t wr_addr,
    output mem_bus_pkg::line_t      wr_data,
    input  logic                    wr_rdy
);

    cache_pkg::main_state_e                             state;
    logic                                               victim_way;
    cache_pkg::tagv_t [cache_pkg::num_ways-1:0]         tagv_rd;
    logic [cache_pkg::num_ways-1:0]                     dirty_rd;
    mem_bus_pkg::line_t [cache_pkg::num_ways-1:0]       bank_rd;
    cache_pkg::cpu_req_t                                buf_req;
    cache_pkg::lookup_res_t                             lres;
    logic [31:0]                                        hit_rdata;
    logic                                               sb_wen;
    logic                                               sb_way;
    cache_pkg::index_t                                  sb_index;
    logic [1:0]                                         sb_bank;
    logic [3:0]                                         sb_wstrb;
    logic [31:0]                                        sb_wdata;
    logic [cache_pkg::words_per_line-1:0]               refill_wen;
    logic [31:0]                                        refill_wdata;
    logic                                               tag_wen;

    hit_lookup u_hit_lookup (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .req        (req),
        .state      (state),
        .victim_way (victim_way),
        .tagv_rd    (tagv_rd),
        .dirty_rd   (dirty_rd),
        .bank_rd    (bank_rd),
        .addr_ok    (addr_ok),
        .buf_req    (buf_req),
        .lres       (lres),
        .hit_rdata  (hit_rdata),
        .sb_wen     (sb_wen),
        .sb_way     (sb_way),
        .sb_index   (sb_index),
        .sb_bank    (sb_bank),
        .sb_wstrb   (sb_wstrb),
        .sb_wdata   (sb_wdata)
    );

    miss_ctrl #(
        .lfsr_seed (lfsr_seed)
    ) u_miss_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .addr_ok      (addr_ok),
        .buf_req      (buf_req),
        .lres         (lres),
        .hit_rdata    (hit_rdata),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_rdy       (wr_rdy),
        .victim_line  (bank_rd[victim_way]),
        .state        (state),
        .victim_way   (victim_way),
        .refill_wen   (refill_wen),
        .refill_wdata (refill_wdata),
        .tag_wen      (tag_wen),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data)
    );

    cache_arrays u_cache_arrays (
        .clk          (clk),
        .resetn       (resetn),
        .state        (state),
        .rd_index     (req.index),      // incoming request, read ahead of lookup
        .sb_wen       (sb_wen),
        .sb_way       (sb_way),
        .sb_index     (sb_index),
        .sb_bank      (sb_bank),
        .sb_wstrb     (sb_wstrb),
        .sb_wdata     (sb_wdata),
        .victim_way   (victim_way),
        .refill_index (buf_req.index),
        .refill_wen   (refill_wen),
        .refill_wdata (refill_wdata),
        .tag_wen      (tag_wen),
        .refill_tag   (buf_req.tag),
        .tagv_rd      (tagv_rd),
        .dirty_rd     (dirty_rd),
        .bank_rd      (bank_rd)
    );

endmodule

// ==== cache_asserts.sv ====
module cache_asserts (
    input logic                   clk,
    input logic                   resetn,
    input logic                   addr_ok,
    input logic                   rd_req,
    input logic                   rd_rdy,
    input logic                   wr_req,
    input cache_pkg::main_state_e state
);

    // write-back request is a single pulse
    a_wr_pulse: assert property (@(posedge clk) disable iff (!resetn) wr_req |=> !wr_req)
        else $error("wr_req held longer than one cycle");

    a_wr_in_replace: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> state == cache_pkg::st_replace)
        else $error("wr_req outside replace");

    // line read stays up until the memory takes it
    a_rd_hold: assert property (@(posedge clk) disable iff (!resetn) rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    a_busy_stall: assert property (@(posedge clk) disable iff (!resetn)
        state inside {cache_pkg::st_miss, cache_pkg::st_replace, cache_pkg::st_refill} |-> !addr_ok)
        else $error("addr_ok high while handling a miss");

endmodule

bind cache_top cache_asserts u_asserts (.*);

// ==== cache_checker.sv ====
module cache_checker (
    input logic                    clk,
    input logic                    resetn,
    input logic                    valid,
    input logic                    addr_ok,
    input cache_pkg::cpu_req_t     req,
    input logic                    data_ok,
    input logic [31:0]             rdata,
    input logic                    rd_req,
    input mem_bus_pkg::line_addr_t rd_addr,
    input logic                    wr_req,
    input mem_bus_pkg::line_addr_t wr_addr,
    input mem_bus_pkg::line_t      wr_data
);

    logic [31:0]             exp_val [$];
    logic                    exp_read [$];
    logic                    exp_hit [$];
    int                      acc_cyc [$];
    int                      cyc = 0;
    int                      test_errs = 0;
    int                      total_errs = 0;
    int                      tests_run = 0;
    int                      wb_seen = 0;
    int                      rd_seen = 0;
    string                   cur_test = "none";
    mem_bus_pkg::line_addr_t last_line = '0;
    logic                    rd_req_q = 1'b0;

    function automatic void fail_value(string what, logic [31:0] exp, logic [31:0] act);
        $display("[ERROR] test %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        test_errs++;
    endfunction

    function automatic void fail_text(string msg);
        $display("test %s: %s", cur_test, msg);
        test_errs++;
    endfunction

    // tb hands in the golden result of each accepted request
    function automatic void expect_resp(logic is_read, logic [31:0] value, logic hit);
        exp_val.push_back(value);
        exp_read.push_back(is_read);
        exp_hit.push_back(hit);
    endfunction

    function automatic int pending();
        return exp_val.size();
    endfunction

    function automatic void start_test(string name);
        cur_test  = name;
        test_errs = 0;
        wb_seen   = 0;
        rd_seen   = 0;
    endfunction

    function automatic void check_idle();
        if (!addr_ok || data_ok || rd_req || wr_req) begin
            fail_text("outputs not idle after reset");
        end
    endfunction

    function automatic void expect_writeback();
        if (wb_seen == 0) begin
            fail_text("no dirty line was written back");
        end
    endfunction

    function automatic void expect_no_refill();
        if (rd_seen != 0) begin
            fail_text("a hit read requested a line from memory");
        end
    endfunction

    function automatic void end_test();
        $display("test %s: %s (%0d errors)", cur_test, test_errs == 0 ? "ok" : "bad", test_errs);
        total_errs += test_errs;
        tests_run++;
    endfunction

    function automatic int summary();
        $display("tests run %0d, errors %0d", tests_run, total_errs);
        return total_errs;
    endfunction

    always @(negedge clk) begin
        cyc++;
        if (resetn) begin
            if (data_ok) begin
                if (exp_val.size() == 0 || acc_cyc.size() == 0) begin
                    fail_text("data_ok with no request outstanding");
                end else begin
                    if (exp_read.pop_front() && rdata != exp_val[0]) begin
                        fail_value("rdata", exp_val[0], rdata);
                    end
                    if (exp_hit.pop_front() && cyc - acc_cyc[0] != 1) begin
                        fail_text("hit did not answer one cycle after acceptance");
                    end
                    void'(exp_val.pop_front());
                    void'(acc_cyc.pop_front());
                end
            end
            if (valid && addr_ok) begin
                acc_cyc.push_back(cyc);
                last_line = '{tag: req.tag, index: req.index, pad: 4'h0};
            end
            if (rd_req && !rd_req_q) begin
                rd_seen++;
                if (rd_addr != last_line) begin
                    fail_value("rd_addr", last_line, rd_addr);
                end
            end
            rd_req_q = rd_req;
            if (wr_req) begin
                wb_seen++;
                for (int i = 0; i < 4; i++) begin
                    if (wr_data[i] != tb_cache.golden_word(wr_addr + 32'(4 * i))) begin
                        fail_value("wr_data", tb_cache.golden_word(wr_addr + 32'(4 * i)),
                                   wr_data[i]);
                    end
                end
            end
        end
    end

endmodule

// ==== tb_cache.sv ====
module tb_cache;

    logic                    clk;
    logic                    resetn;
    logic                    valid;
    cache_pkg::cpu_req_t     req;
    logic                    addr_ok;
    logic                    data_ok;
    logic [31:0]             rdata;
    logic                    rd_req;
    mem_bus_pkg::line_addr_t rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic                    ret_last;
    logic [31:0]             ret_data;
    logic                    wr_req;
    mem_bus_pkg::line_addr_t wr_addr;
    mem_bus_pkg::line_t      wr_data;
    logic                    wr_rdy;

    logic [31:0]             mem_words [logic [31:0]];  // memory model keyed by byte address
    logic [31:0]             golden [logic [31:0]];
    logic [31:0]             lcg_state;
    logic                    hung;
    logic                    verdict_done;
    logic                    refilling;
    int                      ret_cnt;
    logic [31:0]             ret_base;
    logic                    seen_wr;
    logic                    seen_rd;
    logic                    seen_rreq;
    logic [31:0]             seen_waddr;
    logic [31:0]             seen_raddr;
    mem_bus_pkg::line_t      seen_wline;
    logic [31:0]             a;
    logic [7:0]              rb;
    int                      errs;

    cache_top UUT (.*);

    cache_checker u_checker (.*);

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function logic [31:0] golden_word(logic [31:0] addr);
        return golden.exists(addr) ? golden[addr] : fill_word(addr);
    endfunction

    function logic [31:0] mem_read(logic [31:0] addr);
        return mem_words.exists(addr) ? mem_words[addr] : fill_word(addr);
    endfunction

    // a read returns the golden word and a store merges in its strobed bytes
    function logic [31:0] ref_result(logic is_write, logic [31:0] addr, logic [3:0] wstrb,
                                     logic [31:0] wdata);
        logic [31:0] w;
        w = golden_word(addr);
        for (int i = 0; i < 4; i++) begin
            if (is_write && wstrb[i]) begin
                w[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge hung) begin
        $display("run stopped, the DUT did not respond in time");
        verdict_done = 1'b1;
        $display("TESTBENCH FAILED");
        $finish;
    end

    always @(negedge clk) begin
        seen_wr    = wr_req;
        seen_waddr = wr_addr;
        seen_wline = wr_data;
        seen_rd    = rd_req && rd_rdy;
        seen_rreq  = rd_req;
        seen_raddr = rd_addr;
    end

    // memory model answers on the edge after it saw a request
    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            refilling <= 1'b0;
            ret_cnt   <= 0;
        end else begin
            wr_rdy <= rand_byte() < 8'd160;
            if (seen_wr) begin
                for (int i = 0; i < 4; i++) begin
                    mem_words[seen_waddr + 32'(4 * i)] = seen_wline[i];
                end
            end
            if (seen_rd) begin
                rd_rdy    <= 1'b0;
                refilling <= 1'b1;
                ret_base  <= seen_raddr;
                ret_cnt   <= 0;
            end else if (seen_rreq && !refilling && !rd_rdy) begin
                rd_rdy <= rand_byte() < 8'd128;
            end
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (refilling && rand_byte() < 8'd192) begin
                ret_valid <= 1'b1;
                ret_data  <= mem_read(ret_base + 32'(4 * ret_cnt));
                ret_last  <= ret_cnt == 3;
                ret_cnt   <= ret_cnt + 1;
                if (ret_cnt == 3) begin
                    refilling <= 1'b0;
                end
            end
        end
    end

    task automatic send(input logic is_write, input logic [31:0] addr, input logic [3:0] wstrb,
                        input logic [31:0] wdata, input logic hit);
        int          t;
        logic [31:0] exp;
        t = 0;
        @(posedge clk);
        valid <= 1'b1;
        req   <= '{op: is_write ? cache_pkg::op_write : cache_pkg::op_read,
                   index: addr[11:4], tag: addr[31:12], offset: addr[3:0],
                   wstrb: wstrb, wdata: wdata};
        @(negedge clk);
        while (!addr_ok && !hung) begin
            t++;
            if (t > 2000) begin
                $display("request to %h was never accepted", addr);
                hung = 1'b1;
            end
            @(negedge clk);
        end
        exp = ref_result(is_write, addr, wstrb, wdata);
        if (is_write) begin
            golden[addr] = exp;
        end
        u_checker.expect_resp(!is_write, exp, hit);
    endtask

    task automatic drain();
        int t;
        t = 0;
        @(posedge clk);
        valid <= 1'b0;
        while (u_checker.pending() > 0 && !hung) begin
            t++;
            if (t > 2000) begin
                $display("responses still missing after the last request");
                hung = 1'b1;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        resetn       = 1'b0;
        valid        = 1'b0;
        req          = '0;
        rd_rdy       = 1'b0;
        wr_rdy       = 1'b0;
        ret_valid    = 1'b0;
        ret_last     = 1'b0;
        ret_data     = '0;
        hung         = 1'b0;
        verdict_done = 1'b0;
        lcg_state    = 32'h6bda;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        u_checker.start_test("reset");
        u_checker.check_idle();
        u_checker.end_test();

        u_checker.start_test("read_miss");
        send(1'b0, 32'h0001_2348, 4'h0, 32'h0, 1'b0);
        drain();
        u_checker.end_test();

        u_checker.start_test("read_hit");
        send(1'b0, 32'h0001_2348, 4'h0, 32'h0, 1'b1);
        send(1'b0, 32'h0001_2340, 4'h0, 32'h0, 1'b1);
        drain();
        u_checker.expect_no_refill();
        u_checker.end_test();

        u_checker.start_test("store_load");
        send(1'b1, 32'h0001_2348, 4'b0011, 32'hdead_beef, 1'b1);
        send(1'b0, 32'h0001_2348, 4'h0, 32'h0, 1'b1);
        send(1'b1, 32'h0001_2348, 4'b1100, 32'h1234_5678, 1'b1);
        send(1'b0, 32'h0001_2348, 4'h0, 32'h0, 1'b1);
        send(1'b1, 32'h0004_5674, 4'b0101, 32'hcafe_f00d, 1'b0);  // write miss
        send(1'b0, 32'h0004_5674, 4'h0, 32'h0, 1'b1);
        drain();
        u_checker.end_test();

        u_checker.start_test("dirty_eviction");
        send(1'b1, 32'h1000_0a50, 4'b1111, 32'h1111_1111, 1'b0);
        send(1'b1, 32'h2000_0a54, 4'b0110, 32'h2222_2222, 1'b0);
        send(1'b1, 32'h3000_0a58, 4'b1001, 32'h3333_3333, 1'b0);
        send(1'b0, 32'h1000_0a50, 4'h0, 32'h0, 1'b0);
        send(1'b0, 32'h2000_0a54, 4'h0, 32'h0, 1'b0);
        send(1'b0, 32'h3000_0a58, 4'h0, 32'h0, 1'b0);
        drain();
        u_checker.expect_writeback();
        u_checker.end_test();

        u_checker.start_test("random");
        for (int n = 0; n < 400; n++) begin
            rb = rand_byte();
            a  = {17'd0, rb[7:5], 6'd0, rb[4:3], rb[2:1], 2'b00};
            rb = rand_byte();
            send(rb[0], a, rb[4:1] | 4'b0001, {4{rand_byte()}} ^ a, 1'b0);
        end
        drain();
        u_checker.end_test();

        errs = u_checker.summary();
        verdict_done = 1'b1;
        if (errs == 0 && !hung) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    final begin
        if (!verdict_done) begin
            $display("TESTBENCH FAILED");
        end
    end

endmodule

// ==== cache_top.f ====
cache_pkg.sv
mem_bus_pkg.sv
cache_arrays.sv
hit_lookup.sv
miss_ctrl.sv
cache_top.sv
cache_asserts.sv
cache_checker.sv
tb_cache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cache
FILELIST  = cache_top.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
